//--- Makefile
PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rv32CoreTb -Mdir obj_dir
	@out="$$(./obj_dir/Vrv32CoreTb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

//--- dv/rv32CoreAsserts.sv
`timescale 1ns/100ps

module rv32CoreAsserts (
   input logic       clk,
   input logic       reset,
   input logic       memRstrb,
   input logic [3:0] memWmask
);

   logic strobeSeen;  // First strobe since reset

   always_ff @(posedge clk) begin
      if (!reset) strobeSeen <= 1'b0;
      else if (memRstrb) strobeSeen <= 1'b1;
   end

   noReadWithWrite: assert property (@(posedge clk) disable iff (!reset)
      !(memRstrb && memWmask != 4'b0))
      else $error("memRstrb and memWmask active together");

   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memWmask inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
      else $error("memWmask has an illegal lane pattern");

   noEarlyWrite: assert property (@(posedge clk) disable iff (!reset)
      !strobeSeen |-> memWmask == 4'h0)
      else $error("memWmask active before the first fetch strobe");

endmodule

bind rv32Core rv32CoreAsserts rv32CoreAsserts_i (
   .clk(clk), .reset(reset), .memRstrb(memRstrb), .memWmask(memWmask)
);

//--- dv/rv32CoreTb.sv
`timescale 1ns/100ps

module rv32CoreTb;
   import rv32Pkg::*;

   localparam int randomCount   = 200;
   localparam int epilogueStart = randomCount + 1;  // Register dump stores start here
   localparam int programLength = randomCount + 33; // LUI, random body, 31 dumps, self-loop
   localparam int loopIndex     = programLength - 1;
   localparam int memWords      = 4096;
   localparam int dataBase      = 32'h1000;         // Data window, held in x1

   logic        clk;
   logic        reset;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic        memRstrb, memRbusy, memWbusy;

   integer      seed = 36;
   logic [31:0] mem [memWords];      // Memory seen by the DUT
   logic [31:0] refMem [memWords];   // Reference model copy
   logic [31:0] refRegs [32];
   logic [31:0] refPc;
   logic [31:0] readWord;            // Held until the next strobe
   logic [31:0] expLoadAddr, expStoreAddr, expStoreData;
   logic [3:0]  expStoreMask;
   bit          expectLoad, storePending, fetchSeen;
   int          loopFetches;
   int          i;

   rv32Core #(.addrWidth(24), .resetAddr(32'h0)) rv32Core_i (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   always #10 clk = ~clk; // 20 ns period

   function automatic int unsigned randBelow(int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Instruction encoders, major opcode plus the fixed 11 low bits
   function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [4:0] op);
      return {f7, rs2, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [4:0] op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   // Reference ALU straight from the ISA rules
   function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'b0, $signed(a) < $signed(b)};
         3'd3:    return {31'b0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;  // BGEU, the generator makes no others
      endcase
   endfunction

   function automatic logic [31:0] loadExtract(logic [2:0] f3, logic [31:0] word,
                                               logic [1:0] offs);
      logic [31:0] shifted;
      shifted = word >> (8 * offs);
      case (f3)
         3'd0:    return {{24{shifted[7]}}, shifted[7:0]};
         3'd1:    return {{16{shifted[15]}}, shifted[15:0]};
         3'd4:    return {24'b0, shifted[7:0]};
         3'd5:    return {16'b0, shifted[15:0]};
         default: return word;
      endcase
   endfunction

   function automatic logic [3:0] storeLanes(logic [2:0] f3, logic [1:0] offs);
      case (f3[1:0])
         2'd0:    return 4'b0001 << offs;
         2'd1:    return 4'b0011 << offs;
         default: return 4'b1111;
      endcase
   endfunction

   function automatic logic [31:0] laneBits(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic check(string name, logic [31:0] got, logic [31:0] expected);
      if (got !== expected) begin
         $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic failRun(string reason);
      $display("At %0t ns: %s", $time, reason);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // x1 stays at the data window, random rd never touches it
   task automatic buildProgram();
      logic [2:0]  branchCodes [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      logic [2:0]  loadCodes [5]   = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      logic [4:0]  rd, rs1, rs2;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [31:0] word;
      int          n, kind, k;
      for (n = 0; n < memWords; n++) begin
         mem[n] = (n * 32'h9e37_79b1) ^ 32'h5a5a_0000; // Whole address in the pattern
      end
      mem[0] = encU(20'h1, 5'd1, opLui);
      for (n = 1; n <= randomCount; n++) begin
         rd   = 5'(randBelow(30) + 2);
         rs1  = 5'(randBelow(32));
         rs2  = 5'(randBelow(32));
         f3   = 3'(randBelow(8));
         imm  = 12'(randBelow(4096));
         kind = int'(randBelow(10));
         case (kind)
            0, 1, 2: word = encR(((f3 == 3'd0 || f3 == 3'd5) && randBelow(2) == 1) ?
                                 7'h20 : 7'h00, rs2, rs1, f3, rd, opAluReg);
            3, 4, 5: begin
               if (f3 == 3'd1) imm = {7'h0, imm[4:0]};         // SLLI shamt only
               else if (f3 == 3'd5) imm = {1'b0, imm[10], 5'h0, imm[4:0]}; // SRLI or SRAI
               word = encI(imm, rs1, f3, rd, opAluImm);
            end
            6: word = encU(20'(randBelow(1 << 20)), rd, randBelow(2) == 1 ? opLui : opAuipc);
            7: begin
               f3  = loadCodes[randBelow(5)];
               imm = 12'(randBelow(256));
               if (f3[1:0] == 2'd1) imm[0] = 1'b0;
               if (f3[1:0] == 2'd2) imm[1:0] = 2'b00;
               word = encI(imm, 5'd1, f3, rd, opLoad);
            end
            8: begin
               f3  = 3'(randBelow(3));
               imm = 12'(randBelow(256));
               if (f3 == 3'd1) imm[0] = 1'b0;
               if (f3 == 3'd2) imm[1:0] = 2'b00;
               word = encS(imm, rs2, 5'd1, f3);
            end
            default: begin
               k = int'(randBelow(5)) + 1;  // Skips 0 to 4 instructions
               if (n + k > epilogueStart) k = epilogueStart - n;
               case (randBelow(3))
                  0:       word = encB(13'(4 * k), rs2, rs1, branchCodes[randBelow(6)]);
                  1:       word = encJ(21'(4 * k), rd);
                  default: word = encI(12'(4 * (n + k)), 5'd0, 3'd0, rd, opJalr);
               endcase
            end
         endcase
         mem[n] = word;
      end
      for (n = 1; n < 32; n++) begin
         mem[epilogueStart + n - 1] = encS(12'(256 + 4 * n), 5'(n), 5'd1, f3Word);
      end
      mem[loopIndex] = encJ(21'd0, 5'd0); // Self-loop ends the program
      for (n = 0; n < memWords; n++) refMem[n] = mem[n];
   endtask

   // Executes one instruction at refPc and records what the bus must show
   task automatic refStep();
      logic [31:0] ins, a, b, immI, immS, immB, immU, immJ;
      logic [31:0] nextPc, addr, result;
      logic [11:0] idx;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic        writes;
      int          n;
      ins    = refMem[refPc[13:2]];
      rd     = ins[11:7];
      f3     = ins[14:12];
      a      = refRegs[ins[19:15]];
      b      = refRegs[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      immU   = {ins[31:12], 12'b0};
      immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = refPc + 4;
      writes = 1'b1;
      result = '0;
      case (ins[6:2])
         opLui:   result = immU;
         opAuipc: result = refPc + immU;
         opJal: begin
            result = refPc + 4;
            nextPc = refPc + immJ;
         end
         opJalr: begin
            result = refPc + 4;
            nextPc = (a + immI) & ~32'd1;
         end
         opBranch: begin
            writes = 1'b0;
            if (branchTaken(f3, a, b)) nextPc = refPc + immB;
         end
         opLoad: begin
            addr        = a + immI;
            result      = loadExtract(f3, refMem[addr[13:2]], addr[1:0]);
            expectLoad  = 1'b1;
            expLoadAddr = addr;
         end
         opStore: begin
            writes       = 1'b0;
            addr         = a + immS;
            idx          = addr[13:2];
            expStoreAddr = addr;
            expStoreMask = storeLanes(f3, addr[1:0]);
            expStoreData = b << (8 * addr[1:0]);
            storePending = 1'b1;
            for (n = 0; n < 4; n++) begin
               if (expStoreMask[n]) refMem[idx][8*n +: 8] = expStoreData[8*n +: 8];
            end
         end
         opAluImm: result = aluRef(f3, (f3 == 3'd5) & ins[30], a, immI);
         opAluReg: result = aluRef(f3, ins[30], a, b);
         default:  writes = 1'b0;  // SYSTEM and anything else
      endcase
      if (writes && rd != 5'd0) refRegs[rd] = result;
      refPc = nextPc;
   endtask

   // Bus monitor and memory; answers one cycle after a strobe
   always @(posedge clk) begin
      if (reset) begin
         if (memWmask != 4'b0) begin
            if (!fetchSeen) failRun("Memory write before the first instruction fetch");
            if (!storePending) failRun("Memory write that the program does not make");
            check("memAddr", memAddr, expStoreAddr);
            check("memWmask", {28'b0, memWmask}, {28'b0, expStoreMask});
            check("memWdata", memWdata & laneBits(memWmask),
                  expStoreData & laneBits(expStoreMask));
            for (i = 0; i < 4; i++) begin
               if (memWmask[i]) mem[memAddr[13:2]][8*i +: 8] = memWdata[8*i +: 8];
            end
            storePending = 1'b0;
         end
         if (memRstrb) begin
            if (expectLoad) begin
               check("memAddr", memAddr, expLoadAddr);
               expectLoad = 1'b0;
            end else begin
               if (storePending) failRun("Store instruction ended without a memory write");
               check("memAddr", memAddr, {refPc[31:2], 2'b00}); // Fetch address
               fetchSeen = 1'b1;
               if (refPc == 32'(loopIndex * 4)) loopFetches++;
               refStep();
            end
            readWord = mem[memAddr[13:2]];
         end
      end
      #2;
      memRdata = readWord;
      memRbusy = (randBelow(4) == 0);  // Busy about a quarter of the time
      memWbusy = (randBelow(4) == 0);
   end

   initial begin
      #(programLength * 40 * 20);
      $display("Watchdog timeout, the program did not reach its final loop");
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b0;
      memRdata     = '0;
      memRbusy     = 1'b0;
      memWbusy     = 1'b0;
      refPc        = 32'h0;
      readWord     = '0;
      expectLoad   = 1'b0;
      storePending = 1'b0;
      fetchSeen    = 1'b0;
      loopFetches  = 0;
      for (i = 0; i < 32; i++) refRegs[i] = '0;
      buildProgram();
      repeat (3) @(posedge clk);
      #2 reset = 1'b1;
      wait (loopFetches >= 2);
      repeat (4) @(posedge clk);
      // Random stores and register dump land in the data window
      for (i = dataBase / 4; i < dataBase / 4 + 128; i++) begin
         check($sformatf("mem[%h]", i * 4), mem[i], refMem[i]);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
   input  logic [rv32Pkg::xlen-1:0] rs1,
   input  logic [rv32Pkg::xlen-1:0] rs2,
   input  logic [rv32Pkg::xlen-1:0] immI,
   input  logic                     isAluReg,
   input  logic                     isBranch,
   input  logic [2:0]               funct3,
   input  logic                     altOp,
   output logic [rv32Pkg::xlen-1:0] aluOut,
   output logic [rv32Pkg::xlen-1:0] aluPlus,   // Also JALR target
   output logic                     predicate  // Branch taken
);
   import rv32Pkg::*;

   logic [xlen-1:0] aluIn2;
   logic [xlen:0]   aluMinus;   // Carry out gives unsigned compare
   logic            lt, ltu, eq;
   logic [xlen-1:0] shiftIn, shiftRight;

   function automatic logic [xlen-1:0] bitReverse(input logic [xlen-1:0] value);
      logic [xlen-1:0] result;
      for (int i = 0; i < xlen; i++) begin
         result[i] = value[xlen-1-i];
      end
      return result;
   endfunction

   assign aluIn2  = (isAluReg | isBranch) ? rs2 : immI; // Loads and JALR take immI
   assign aluPlus = rs1 + aluIn2;

   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign ltu = aluMinus[xlen];
   assign lt  = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
   assign eq  = (aluMinus[xlen-1:0] == '0);

   // Left shift goes through the right shifter on reversed bits
   assign shiftIn    = (funct3 == f3Sll) ? bitReverse(rs1) : rs1;
   assign shiftRight = xlen'($signed({altOp & rs1[xlen-1], shiftIn}) >>> aluIn2[4:0]);

   always_comb begin
      case (funct3)
         f3Add:   aluOut = altOp ? aluMinus[xlen-1:0] : aluPlus;
         f3Sll:   aluOut = bitReverse(shiftRight);
         f3Slt:   aluOut = {{(xlen-1){1'b0}}, lt};
         f3Sltu:  aluOut = {{(xlen-1){1'b0}}, ltu};
         f3Xor:   aluOut = rs1 ^ aluIn2;
         f3Srl:   aluOut = shiftRight;     // Arithmetic when altOp set
         f3Or:    aluOut = rs1 | aluIn2;
         default: aluOut = rs1 & aluIn2;   // f3And
      endcase
   end

   always_comb begin
      case (funct3)
         f3Beq:   predicate = eq;
         f3Bne:   predicate = ~eq;
         f3Blt:   predicate = lt;
         f3Bge:   predicate = ~lt;
         f3Bltu:  predicate = ltu;
         f3Bgeu:  predicate = ~ltu;
         default: predicate = 1'b0; // 010 and 011 are not branches
      endcase
   end

endmodule

//--- hdl/controlFsm.sv
`timescale 1ns/100ps

module controlFsm #(
   parameter int          addrWidth = 24,
   parameter logic [31:0] resetAddr = 32'h0
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [rv32Pkg::xlen-1:0]        memRdata,
   input  logic                            memRbusy,
   input  logic                            memWbusy,
   input  logic                            isLoad,
   input  logic                            isAluImm,
   input  logic                            isAuipc,
   input  logic                            isStore,
   input  logic                            isAluReg,
   input  logic                            isLui,
   input  logic                            isBranch,
   input  logic                            isJalr,
   input  logic                            isJal,
   input  logic [rv32Pkg::regIdxWidth-1:0] rdId,
   input  logic [rv32Pkg::xlen-1:0]        immB,
   input  logic [rv32Pkg::xlen-1:0]        immU,
   input  logic [rv32Pkg::xlen-1:0]        immJ,
   input  logic [rv32Pkg::xlen-1:0]        aluOut,
   input  logic [rv32Pkg::xlen-1:0]        aluPlus,
   input  logic                            predicate,
   input  logic [addrWidth-1:0]            lsAddr,
   input  logic [3:0]                      storeMask,
   input  logic [rv32Pkg::xlen-1:0]        loadData,
   output rv32Pkg::instrWordT              instr,
   output logic [rv32Pkg::regIdxWidth-1:0] rs1Id,    // From the raw fetched word
   output logic [rv32Pkg::regIdxWidth-1:0] rs2Id,
   output logic                            decodeEn,
   output logic                            writeBack,
   output logic [rv32Pkg::xlen-1:0]        writeBackData,
   output logic [addrWidth-1:0]            memAddr,
   output logic                            memRstrb,
   output logic [3:0]                      memWmask
);
   import rv32Pkg::*;

   // One-hot state bits
   localparam int fetchBit     = 0;
   localparam int waitInstrBit = 1;
   localparam int executeBit   = 2;
   localparam int waitMemBit   = 3;

   localparam logic [31:0] nopWord = 32'h0000_0013; // ADDI x0, x0, 0

   logic [3:0]           state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4, pcPlusImm, nextPc;
   logic [xlen-1:0]      pcImm;
   logic                 isSystem;
   instrWordT            fetched;  // Memory word seen as an instruction

   assign fetched = memRdata;
   assign rs1Id   = fetched.r.rs1;
   assign rs2Id   = fetched.r.rs2;

   assign isSystem = (instr.r.opcode[6:2] == opSystem);

   // Shared adder for JAL and branch targets
   assign pcImm     = isJal ? immJ : immB;
   assign pcPlusImm = pc + pcImm[addrWidth-1:0];
   assign pcPlus4   = pc + addrWidth'(4);
   assign nextPc    = isJalr ? {aluPlus[addrWidth-1:1], 1'b0} :
                      (isJal | (isBranch & predicate)) ? pcPlusImm : pcPlus4;

   assign memAddr  = (state[fetchBit] | state[waitInstrBit]) ?
                     {pc[addrWidth-1:2], 2'b00} : lsAddr;
   assign memRstrb = state[fetchBit] | (state[executeBit] & isLoad);
   assign memWmask = {4{state[executeBit] & isStore}} & storeMask;

   assign decodeEn = state[waitInstrBit] & ~memRbusy; // Regfile reads with the latch

   // Loads write once their data shows up in WAIT_MEM
   assign writeBack = (rdId != '0) &
                      ((state[executeBit] & ~(isBranch | isStore | isLoad | isSystem)) |
                       (state[waitMemBit] & isLoad & ~memRbusy));

   // AUIPC result keeps all 32 bits of pc plus immU
   assign writeBackData =
      (isLui                 ? immU                                          : '0) |
      ((isAluImm | isAluReg) ? aluOut                                        : '0) |
      (isAuipc               ? ({{(xlen-addrWidth){1'b0}}, pc} + immU)       : '0) |
      ((isJal | isJalr)      ? {{(xlen-addrWidth){1'b0}}, pcPlus4}           : '0) |
      (isLoad                ? loadData                                      : '0);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= 4'b1 << waitMemBit;  // Wait for idle memory first
         pc    <= resetAddr[addrWidth-1:0];
         instr <= nopWord;             // No stale load or write-back
      end else begin
         case (1'b1)
            state[waitInstrBit]: begin
               if (!memRbusy) begin
                  instr <= fetched;
                  state <= 4'b1 << executeBit;
               end
            end
            state[executeBit]: begin
               pc    <= nextPc;
               state <= (isLoad | isStore) ? 4'b1 << waitMemBit : 4'b1 << fetchBit;
            end
            state[waitMemBit]: begin
               if (!memRbusy && !memWbusy) state <= 4'b1 << fetchBit;
            end
            default: state <= 4'b1 << waitInstrBit; // Fetch strobe just went out
         endcase
      end
   end

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
   input  rv32Pkg::instrWordT              instr,
   output logic                            isLoad,
   output logic                            isAluImm,
   output logic                            isAuipc,
   output logic                            isStore,
   output logic                            isAluReg,
   output logic                            isLui,
   output logic                            isBranch,
   output logic                            isJalr,
   output logic                            isJal,
   output logic [rv32Pkg::regIdxWidth-1:0] rdId,
   output logic [2:0]                      funct3,
   output logic                            altOp,  // SUB or SRA
   output logic [rv32Pkg::xlen-1:0]        immI,
   output logic [rv32Pkg::xlen-1:0]        immS,
   output logic [rv32Pkg::xlen-1:0]        immB,
   output logic [rv32Pkg::xlen-1:0]        immU,
   output logic [rv32Pkg::xlen-1:0]        immJ
);
   import rv32Pkg::*;

   logic [4:0] majorOp;
   logic       signBit; // Bit 31, shared by every immediate

   assign majorOp = instr.r.opcode[6:2]; // Low two bits are always 11 in RV32I
   assign signBit = instr.r.funct7[6];

   // Instruction classes
   assign isLoad   = (majorOp == opLoad);
   assign isAluImm = (majorOp == opAluImm);
   assign isAuipc  = (majorOp == opAuipc);
   assign isStore  = (majorOp == opStore);
   assign isAluReg = (majorOp == opAluReg);
   assign isLui    = (majorOp == opLui);
   assign isBranch = (majorOp == opBranch);
   assign isJalr   = (majorOp == opJalr);
   assign isJal    = (majorOp == opJal);

   assign rdId   = instr.r.rd;
   assign funct3 = instr.r.funct3;

   // Bit 30 is part of the ADDI immediate, so only trust it for
   // register ops and for the right shifts
   assign altOp = instr.r.funct7[5] & (isAluReg | (instr.r.funct3 == f3Srl));

   // Immediates, R/I view for I, S/B view for the split formats
   assign immI = {{21{signBit}}, instr.r.funct7[5:0], instr.r.rs2};
   assign immS = {{21{signBit}}, instr.s.immHi[5:0], instr.s.immLo};
   assign immB = {{20{signBit}}, instr.s.immLo[0], instr.s.immHi[5:0],
                  instr.s.immLo[4:1], 1'b0};  // Bit 11 hides in rd position
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{signBit}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

//--- hdl/loadStoreUnit.sv
`timescale 1ns/100ps

module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  logic [rv32Pkg::xlen-1:0] rs1,
   input  logic [rv32Pkg::xlen-1:0] rs2,
   input  logic [rv32Pkg::xlen-1:0] immI,
   input  logic [rv32Pkg::xlen-1:0] immS,
   input  logic                     isStore,
   input  logic [2:0]               funct3,
   input  logic [rv32Pkg::xlen-1:0] memRdata,
   output logic [addrWidth-1:0]     lsAddr,
   output logic [rv32Pkg::xlen-1:0] memWdata,  // rs2 steered into lanes
   output logic [3:0]               storeMask,
   output logic [rv32Pkg::xlen-1:0] loadData
);
   import rv32Pkg::*;

   logic [xlen-1:0] offset;
   logic [15:0]     loadHalf;
   logic [7:0]      loadByte;
   logic            loadSign;

   assign offset = isStore ? immS : immI;
   assign lsAddr = rs1[addrWidth-1:0] + offset[addrWidth-1:0];

   // Byte data repeats in every lane, halfword in both halves
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2[7:0] :
                            lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      case (funct3[1:0])
         f3Byte[1:0]: storeMask = 4'b0001 << lsAddr[1:0];
         f3Half[1:0]: storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
         f3Word[1:0]: storeMask = 4'b1111;
         default:     storeMask = 4'b0000; // Not a legal store width
      endcase
   end

   // Pick the addressed half, then the addressed byte inside it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~funct3[2] &
                     ((funct3[1:0] == f3Byte[1:0]) ? loadByte[7] : loadHalf[15]);

   always_comb begin
      case (funct3[1:0])
         f3Byte[1:0]: loadData = {{24{loadSign}}, loadByte};
         f3Half[1:0]: loadData = {{16{loadSign}}, loadHalf};
         default:     loadData = memRdata;  // Whole word
      endcase
   end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile (
   input  logic                            clk,
   input  logic                            decodeEn,      // Capture both reads
   input  logic [rv32Pkg::regIdxWidth-1:0] rs1Id,
   input  logic [rv32Pkg::regIdxWidth-1:0] rs2Id,
   input  logic                            writeBack,
   input  logic [rv32Pkg::regIdxWidth-1:0] rdId,
   input  logic [rv32Pkg::xlen-1:0]        writeBackData,
   output logic [rv32Pkg::xlen-1:0]        rs1,
   output logic [rv32Pkg::xlen-1:0]        rs2
);
   import rv32Pkg::*;

   logic [xlen-1:0] regs [0:(1<<regIdxWidth)-1];

   // Entry 0 is never written
   always_ff @(posedge clk) begin
      if (writeBack && (rdId != '0)) begin
         regs[rdId] <= writeBackData;
      end
   end

   // Registered reads, x0 forced to zero here
   always_ff @(posedge clk) begin
      if (decodeEn) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

//--- hdl/rv32Core.sv
`timescale 1ns/100ps

module rv32Core #(
   parameter int          addrWidth = 24,   // Internal address width
   parameter logic [31:0] resetAddr = 32'h0 // First fetch address
) (
   input  logic                     clk,
   input  logic                     reset,    // Active low
   output logic [rv32Pkg::xlen-1:0] memAddr,
   output logic [rv32Pkg::xlen-1:0] memWdata,
   output logic [3:0]               memWmask, // One bit per byte lane
   output logic                     memRstrb, // One-cycle read request
   input  logic [rv32Pkg::xlen-1:0] memRdata, // Shared by fetch and load
   input  logic                     memRbusy,
   input  logic                     memWbusy
);
   import rv32Pkg::*;

   instrWordT              instr;          // Latched instruction
   logic                   isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic                   isLui, isBranch, isJalr, isJal;
   logic [regIdxWidth-1:0] rdId, rs1Id, rs2Id;
   logic [2:0]             funct3;
   logic                   altOp;
   logic [xlen-1:0]        immI, immS, immB, immU, immJ;
   logic [xlen-1:0]        rs1, rs2;
   logic                   decodeEn, writeBack;
   logic [xlen-1:0]        writeBackData;
   logic [xlen-1:0]        aluOut, aluPlus;
   logic                   predicate;
   logic [addrWidth-1:0]   lsAddr, coreAddr;
   logic [3:0]             storeMask;
   logic [xlen-1:0]        loadData;

   assign memAddr = {{(xlen-addrWidth){1'b0}}, coreAddr}; // Pad to the bus width

   instrDecoder decoder_i (
      .instr(instr), .isLoad(isLoad), .isAluImm(isAluImm), .isAuipc(isAuipc),
      .isStore(isStore), .isAluReg(isAluReg), .isLui(isLui), .isBranch(isBranch),
      .isJalr(isJalr), .isJal(isJal), .rdId(rdId), .funct3(funct3), .altOp(altOp),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   regFile regFile_i (
      .clk(clk), .decodeEn(decodeEn), .rs1Id(rs1Id), .rs2Id(rs2Id),
      .writeBack(writeBack), .rdId(rdId), .writeBackData(writeBackData),
      .rs1(rs1), .rs2(rs2)
   );

   alu alu_i (
      .rs1(rs1), .rs2(rs2), .immI(immI), .isAluReg(isAluReg), .isBranch(isBranch),
      .funct3(funct3), .altOp(altOp), .aluOut(aluOut), .aluPlus(aluPlus),
      .predicate(predicate)
   );

   loadStoreUnit #(.addrWidth(addrWidth)) lsu_i (
      .rs1(rs1), .rs2(rs2), .immI(immI), .immS(immS), .isStore(isStore),
      .funct3(funct3), .memRdata(memRdata), .lsAddr(lsAddr), .memWdata(memWdata),
      .storeMask(storeMask), .loadData(loadData)
   );

   controlFsm #(.addrWidth(addrWidth), .resetAddr(resetAddr)) fsm_i (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .isLoad(isLoad), .isAluImm(isAluImm), .isAuipc(isAuipc),
      .isStore(isStore), .isAluReg(isAluReg), .isLui(isLui), .isBranch(isBranch),
      .isJalr(isJalr), .isJal(isJal), .rdId(rdId), .immB(immB), .immU(immU),
      .immJ(immJ), .aluOut(aluOut), .aluPlus(aluPlus), .predicate(predicate),
      .lsAddr(lsAddr), .storeMask(storeMask), .loadData(loadData), .instr(instr),
      .rs1Id(rs1Id), .rs2Id(rs2Id), .decodeEn(decodeEn), .writeBack(writeBack),
      .writeBackData(writeBackData), .memAddr(coreAddr), .memRstrb(memRstrb),
      .memWmask(memWmask)
   );

endmodule

//--- hdl/rv32Pkg.sv
package rv32Pkg;

   localparam int xlen        = 32; // Data and register width
   localparam int regIdxWidth = 5;  // 32 architectural registers

   // Major opcodes, instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000; // rd <- mem[rs1+immI]
   localparam logic [4:0] opAluImm = 5'b00100; // rd <- rs1 op immI
   localparam logic [4:0] opAuipc  = 5'b00101; // rd <- pc + immU
   localparam logic [4:0] opStore  = 5'b01000; // mem[rs1+immS] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100; // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101; // rd <- immU
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;
   localparam logic [4:0] opSystem = 5'b11100; // Executed as a nop

   // Load and store width, bit 2 selects zero extension on loads
   localparam logic [2:0] f3Byte = 3'b000;
   localparam logic [2:0] f3Half = 3'b001;
   localparam logic [2:0] f3Word = 3'b010;

   // ALU operations
   localparam logic [2:0] f3Add  = 3'b000; // ADD or SUB
   localparam logic [2:0] f3Sll  = 3'b001;
   localparam logic [2:0] f3Slt  = 3'b010;
   localparam logic [2:0] f3Sltu = 3'b011;
   localparam logic [2:0] f3Xor  = 3'b100;
   localparam logic [2:0] f3Srl  = 3'b101; // SRL or SRA
   localparam logic [2:0] f3Or   = 3'b110;
   localparam logic [2:0] f3And  = 3'b111;

   // Branch conditions
   localparam logic [2:0] f3Beq  = 3'b000;
   localparam logic [2:0] f3Bne  = 3'b001;
   localparam logic [2:0] f3Blt  = 3'b100;
   localparam logic [2:0] f3Bge  = 3'b101;
   localparam logic [2:0] f3Bltu = 3'b110;
   localparam logic [2:0] f3Bgeu = 3'b111;

   // R and I type layout, I immediate sits in funct7 and rs2
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeT;

   // S and B type layout, immediate split around the register fields
   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeT;

   typedef union packed {
      rTypeT r;
      sTypeT s;
   } instrWordT;

endpackage

//--- sim.f
hdl/rv32Pkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/loadStoreUnit.sv
hdl/controlFsm.sv
hdl/rv32Core.sv
dv/rv32CoreAsserts.sv
dv/rv32CoreTb.sv
